// ==== sim/harness_golden.txt ====
// cmd_addr_be_wdata_rdata_resp, cmd bit 0 write, 1 request, 2 bus reset, 3 dropped
// rdata and resp are the expected response, resp 0 okay, 3 decode error
2_00010000_00_0000000000000000_a5c30f965a3cf069_0
2_00010008_00_0000000000000000_a4c20e975b3df168_0
2_00010028_00_0000000000000000_a0c60a935f39f56c_0
2_000100f8_00_0000000000000000_badc10894523ef76_0
3_00010010_ff_0123456789abcdef_0000000000000000_0
2_00010010_00_0000000000000000_a7c10d94583ef26b_0
// DRAM partial writes and back to back reads
3_80000000_ff_1111111111111111_0000000000000000_0
3_80000000_0f_aaaaaaaabbbbbbbb_0000000000000000_0
2_80000000_00_0000000000000000_11111111bbbbbbbb_0
3_80000008_ff_0123456789abcdef_0000000000000000_0
3_80000008_a5_ffeeddccbbaa9988_0000000000000000_0
2_80000008_00_0000000000000000_ff23dd6789aacd88_0
// Decode errors mixed with decoded requests
2_00000000_00_0000000000000000_0000000000000000_3
2_00010000_00_0000000000000000_a5c30f965a3cf069_0
2_00010100_00_0000000000000000_0000000000000000_3
2_80000000_00_0000000000000000_11111111bbbbbbbb_0
3_80001000_ff_deadbeefdeadbeef_0000000000000000_3
2_fffffff8_00_0000000000000000_0000000000000000_3
// Idle, then traffic lost to the bus reset
0_00000000_00_0000000000000000_0000000000000000_0
0_00000000_00_0000000000000000_0000000000000000_0
0_00000000_00_0000000000000000_0000000000000000_0
2_80000008_00_0000000000000000_ff23dd6789aacd88_0
2_00010008_00_0000000000000000_a4c20e975b3df168_0
e_80000000_00_0000000000000000_0000000000000000_0
a_80000000_00_0000000000000000_0000000000000000_0
0_00000000_00_0000000000000000_0000000000000000_0
2_80000008_00_0000000000000000_ff23dd6789aacd88_0
2_80000000_00_0000000000000000_11111111bbbbbbbb_0

// ==== verilog.f ====
rtl/soc_pkg.sv
rtl/reset_sync.sv
rtl/debug_req_gate.sv
rtl/mem_delay_line.sv
rtl/boot_rom.sv
rtl/sram.sv
rtl/mem_fabric.sv
rtl/harness_top.sv
sim/tb_clk_gen.sv
sim/harness_props.sv
sim/harness_tb.sv

// ==== sim/harness_tb.sv ====
// --------------------------------------------------
// Harness testbench
// Replays golden vectors through the fabric and
// checks responses and the debug request gate
// --------------------------------------------------
`timescale 1ns/1ps

module harness_tb import soc_pkg::*; ();

  localparam int unsigned NumVectors    = 28;
  localparam int unsigned TimeoutCycles = NumVectors + RspLatency + DebugHoldCycles + 50;

  // cmd bits: 0 write, 1 request, 2 bus reset, 3 request is dropped
  typedef struct packed {
    logic [3:0]           cmd;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] rdata;
    logic [3:0]           resp;
  } golden_t;

  typedef struct packed {
    mem_rsp_t    rsp;
    logic [31:0] due;
  } expect_t;

  logic     clk_i;
  logic     rst_ni;
  logic     ndmreset_i;
  logic     req_valid_i;
  mem_req_t req_i;
  logic     rsp_valid_o;
  mem_rsp_t rsp_o;
  logic     debug_enable_i;
  logic     debug_req_i;
  logic     debug_req_o;

  logic [$bits(golden_t)-1:0] golden_mem [NumVectors];
  expect_t                    exp_q [$];
  int unsigned                cycle_cnt    = 0;
  int unsigned                mismatch_cnt = 0;
  int unsigned                other_cnt    = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o ( clk_i )
  );

  harness_top u_harness_top (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .req_valid_i    ( req_valid_i    ),
    .req_i          ( req_i          ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_o          ( rsp_o          ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("timeout after %0d cycles with checks still pending", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Response checker
  // --------------------------------------------------
  always @(negedge clk_i) begin : check_rsp
    expect_t head;
    if (rsp_valid_o === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        other_cnt++;
        $display("response at %0t with no request outstanding", $time);
      end
      if (exp_q.size() > 0) begin
        head = exp_q.pop_front();
        assert (rsp_o === head.rsp && cycle_cnt == head.due) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: got %h resp %0d in cycle %0d, expected %h resp %0d in cycle %0d",
                   $time, rsp_o.rdata, rsp_o.resp, cycle_cnt,
                   head.rsp.rdata, head.rsp.resp, head.due);
        end
      end
    end
    if (exp_q.size() > 0) begin
      assert (exp_q[0].due >= cycle_cnt) else begin
        other_cnt++;
        $display("response missing at %0t for a request due in cycle %0d", $time, exp_q[0].due);
        void'(exp_q.pop_front());
      end
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic run_vectors();
    golden_t  vec;
    mem_req_t req;
    expect_t  exp;
    for (int i = 0; i < NumVectors; i++) begin
      @(posedge clk_i);
      vec       = golden_t'(golden_mem[i]);
      req.we    = vec.cmd[0];
      req.addr  = vec.addr;
      req.be    = vec.be;
      req.wdata = vec.wdata;
      req_valid_i <= vec.cmd[1];
      ndmreset_i  <= vec.cmd[2];
      req_i       <= req;
      // Bus reset loses everything in flight
      if (vec.cmd[2]) begin
        exp_q.delete();
      end
      if (vec.cmd[1] && !vec.cmd[3]) begin
        exp.rsp.rdata = vec.rdata;
        exp.rsp.resp  = resp_e'(vec.resp[1:0]);
        // Counter steps past this edge
        exp.due       = cycle_cnt + 1 + RspLatency;
        exp_q.push_back(exp);
      end
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    ndmreset_i  <= 1'b0;
  endtask

  task automatic check_debug_gate();
    for (int n = 1; n <= DebugHoldCycles; n++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      assert (debug_req_o === 1'b0) else begin
        mismatch_cnt++;
        $display("mismatch at %0t: debug request passed %0d cycles after reset", $time, n);
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    assert (debug_req_o === 1'b1) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: debug request still blocked after the hold window", $time);
    end
    @(posedge clk_i);
    debug_enable_i <= 1'b0;
    @(negedge clk_i);
    assert (debug_req_o === 1'b1) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: debug request dropped before the gate saw the disable", $time);
    end
    @(posedge clk_i);
    @(negedge clk_i);
    assert (debug_req_o === 1'b0) else begin
      mismatch_cnt++;
      $display("mismatch at %0t: debug request high with debug disabled", $time);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    debug_enable_i = 1'b1;
    debug_req_i    = 1'b1;
    $readmemh("sim/harness_golden.txt", golden_mem);
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    fork
      check_debug_gate();
      begin
        // Bus reset releases two edges after rst_ni
        repeat (2) @(posedge clk_i);
        run_vectors();
      end
    join
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    // Room for any stray response
    repeat (RspLatency + 2) @(posedge clk_i);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_cnt, other_cnt, u_harness_top.u_mem_fabric.u_harness_props.fail_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 &&
        u_harness_top.u_mem_fabric.u_harness_props.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/harness_props.sv ====
// --------------------------------------------------
// Fabric properties
// Fixed response latency and no stray responses
// --------------------------------------------------
`timescale 1ns/1ps

module harness_props import soc_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_valid_i,
  input logic     rsp_valid_o,
  input mem_rsp_t rsp_o
);

  int unsigned fail_cnt = 0;

  a_req_gets_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> ##RspLatency rsp_valid_o)
    else begin
      $error("request without a response after the fixed latency");
      fail_cnt++;
    end

  a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> $past(req_valid_i, RspLatency))
    else begin
      $error("response without a matching request");
      fail_cnt++;
    end

  a_rsp_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> !$isunknown(rsp_o))
    else begin
      $error("response payload has unknown bits");
      fail_cnt++;
    end

endmodule

bind mem_fabric harness_props u_harness_props (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .req_valid_i ( req_valid_i ),
  .rsp_valid_o ( rsp_valid_o ),
  .rsp_o       ( rsp_o       )
);

// ==== sim/tb_clk_gen.sv ====
// --------------------------------------------------
// Testbench clock source, 4 ns period
// --------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  localparam int HalfPeriod = 2;

  initial clk_o = 1'b0;

  always #HalfPeriod clk_o = ~clk_o;

endmodule

// ==== rtl/harness_top.sv ====
// --------------------------------------------------
// Harness top level
// Reset generator, debug gate and memory fabric
// --------------------------------------------------
`timescale 1ns/1ps

module harness_top import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ndmreset_i,
  input  logic     req_valid_i,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o,
  input  logic     debug_enable_i,
  input  logic     debug_req_i,
  output logic     debug_req_o
);

  logic sys_rst_n;

  reset_sync u_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  // Gate counts from power-on reset only
  debug_req_gate u_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

  mem_fabric u_mem_fabric (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       )
  );

endmodule

// ==== rtl/mem_fabric.sv ====
// --------------------------------------------------
// Memory fabric
// Decodes requests to ROM, DRAM or error and merges
// the equal-latency responses
// --------------------------------------------------
`timescale 1ns/1ps

module mem_fabric import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o
);

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  logic                   rom_hit;
  logic                   dram_hit;
  logic                   rom_rd_req;
  logic [RomIdxWidth-1:0] rom_word;

  assign rom_hit  = (req_i.addr >= RomBase) && (req_i.addr < RomBase + RomLength);
  assign dram_hit = (req_i.addr >= DramBase) && (req_i.addr < DramBase + DramLength);

  // ROM writes complete as okay but never reach the ROM
  assign rom_rd_req = req_valid_i & rom_hit & ~req_i.we;
  assign rom_word   = req_i.addr[ByteOffset +: RomIdxWidth];

  // --------------------------------------------------
  // ROM and error path
  // --------------------------------------------------
  logic                 pad_vld_q;
  logic                 rom_rd_q;
  logic                 err_q;
  logic [DataWidth-1:0] rom_rdata;
  mem_rsp_t             pad_rsp;
  logic                 pad_vld;
  mem_rsp_t             pad_rsp_q;

  boot_rom u_boot_rom (
    .clk_i   ( clk_i      ),
    .req_i   ( rom_rd_req ),
    .word_i  ( rom_word   ),
    .rdata_o ( rom_rdata  )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_vld_q <= 1'b0;
      rom_rd_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      pad_vld_q <= req_valid_i & ~dram_hit;
      rom_rd_q  <= rom_rd_req;
      err_q     <= req_valid_i & ~dram_hit & ~rom_hit;
    end
  end

  assign pad_rsp.rdata = rom_rd_q ? rom_rdata : '0;
  assign pad_rsp.resp  = err_q ? RespDecErr : RespOkay;

  mem_delay_line #(
    .payload_t ( mem_rsp_t      ),
    .Depth     ( RspLatency - 1 )
  ) u_pad_dly (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .valid_i ( pad_vld_q ),
    .data_i  ( pad_rsp   ),
    .valid_o ( pad_vld   ),
    .data_o  ( pad_rsp_q )
  );

  // --------------------------------------------------
  // DRAM path
  // --------------------------------------------------
  logic                 dram_req_vld;
  mem_req_t             dram_req;
  logic [DataWidth-1:0] sram_rdata;
  logic                 dram_vld_q;
  logic                 dram_rd_q;
  mem_rsp_t             dram_rsp;
  logic                 dram_rsp_vld;
  mem_rsp_t             dram_rsp_q;

  mem_delay_line #(
    .payload_t ( mem_req_t ),
    .Depth     ( DramDelay )
  ) u_req_dly (
    .clk_i   ( clk_i                  ),
    .rst_ni  ( rst_ni                 ),
    .valid_i ( req_valid_i & dram_hit ),
    .data_i  ( req_i                  ),
    .valid_o ( dram_req_vld           ),
    .data_o  ( dram_req               )
  );

  sram u_sram (
    .clk_i   ( clk_i                                     ),
    .req_i   ( dram_req_vld                              ),
    .we_i    ( dram_req.we                               ),
    .word_i  ( dram_req.addr[ByteOffset +: DramIdxWidth] ),
    .be_i    ( dram_req.be                               ),
    .wdata_i ( dram_req.wdata                            ),
    .rdata_o ( sram_rdata                                )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dram_vld_q <= 1'b0;
      dram_rd_q  <= 1'b0;
    end else begin
      dram_vld_q <= dram_req_vld;
      dram_rd_q  <= dram_req_vld & ~dram_req.we;
    end
  end

  assign dram_rsp.rdata = dram_rd_q ? sram_rdata : '0;
  assign dram_rsp.resp  = RespOkay;

  mem_delay_line #(
    .payload_t ( mem_rsp_t ),
    .Depth     ( DramDelay )
  ) u_rsp_dly (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .valid_i ( dram_vld_q   ),
    .data_i  ( dram_rsp     ),
    .valid_o ( dram_rsp_vld ),
    .data_o  ( dram_rsp_q   )
  );

  // At most one path is valid per cycle, so an OR merges them
  assign rsp_valid_o = dram_rsp_vld | pad_vld;
  assign rsp_o = (dram_rsp_vld ? dram_rsp_q : '0) | (pad_vld ? pad_rsp_q : '0);

endmodule

// ==== rtl/sram.sv ====
// --------------------------------------------------
// DRAM model
// Byte-enabled word memory, one-cycle read
// --------------------------------------------------
`timescale 1ns/1ps

module sram import soc_pkg::*; (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [DramIdxWidth-1:0] word_i,
  input  logic [StrbWidth-1:0]    be_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] mem [DramWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes change
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem[word_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_i];
      end
    end
  end

endmodule

// ==== rtl/boot_rom.sv ====
// --------------------------------------------------
// Boot ROM
// Fixed word pattern, registered read
// --------------------------------------------------
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic [RomIdxWidth-1:0] word_i,
  output logic [DataWidth-1:0]   rdata_o
);

  logic [DataWidth-1:0] rom_words [RomWords];

  // Word i is the pattern with i folded into every byte
  for (genvar i = 0; i < RomWords; i++) begin : g_word
    assign rom_words[i] = RomPattern ^ {StrbWidth{8'(i)}};
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_words[word_i];
    end
  end

endmodule

// ==== rtl/mem_delay_line.sv ====
// --------------------------------------------------
// Fixed-depth delay line
// Valid bit and payload shift together, one stage
// per cycle, any payload type
// --------------------------------------------------
`timescale 1ns/1ps

module mem_delay_line import soc_pkg::*; #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = DramDelay
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic [Depth-1:0] valid_q;
  payload_t         data_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < Depth; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q[0] <= data_i;
    for (int i = 1; i < Depth; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign valid_o = valid_q[Depth-1];
  assign data_o  = data_q[Depth-1];

endmodule

// ==== rtl/debug_req_gate.sv ====
// --------------------------------------------------
// Debug request gate
// Blocks debug requests for a hold window after
// reset and whenever debug is disabled
// --------------------------------------------------
`timescale 1ns/1ps

module debug_req_gate import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_enable_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DebugCntWidth-1:0] hold_cnt_q;
  logic                     hold_done;

  assign hold_done = (hold_cnt_q == '0);

  // Hold-off counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= DebugCntWidth'(DebugHoldCycles);
    end else if (!hold_done) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      debug_req_o <= 1'b0;
    end else begin
      debug_req_o <= hold_done & debug_enable_i & debug_req_i;
    end
  end

endmodule

// ==== rtl/reset_sync.sv ====
// --------------------------------------------------
// Reset generator
// Joins power-on reset with the debug reset request,
// asserts at once and releases after two edges
// --------------------------------------------------
`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_join_n;
  logic [1:0] sync_q;

  assign rst_join_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_join_n) begin
    if (!rst_join_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

// ==== rtl/soc_pkg.sv ====
// --------------------------------------------------
// SoC package for the memory-side test harness
// Address map, bus widths, latencies and bus structs
// --------------------------------------------------
package soc_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  // Address map
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0000_0100;
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h0000_1000;

  localparam int unsigned RomWords     = RomLength / StrbWidth;
  localparam int unsigned DramWords    = DramLength / StrbWidth;
  localparam int unsigned RomIdxWidth  = $clog2(RomWords);
  localparam int unsigned DramIdxWidth = $clog2(DramWords);

  // Request delay, one memory cycle, response delay
  localparam int unsigned DramDelay  = 2;
  localparam int unsigned RspLatency = 2 * DramDelay + 1;

  localparam logic [DataWidth-1:0] RomPattern = 64'hA5C3_0F96_5A3C_F069;

  localparam int unsigned DebugHoldCycles = 16;
  localparam int unsigned DebugCntWidth   = $clog2(DebugHoldCycles + 1);

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespDecErr = 2'b11
  } resp_e;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    resp_e                resp;
  } mem_rsp_t;

endpackage
